/* mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Datapath and address width
`define MEM_DATA_WIDTH 32

// Register file index width
`define MEM_REG_ADDR_WIDTH 5

// Data SRAM depth in words, indexed by address bits [9:2]
`define MEM_SRAM_WORDS 256

// RV32I major opcodes handled by this stage
`define MEM_OPCODE_LOAD 7'b0000011
`define MEM_OPCODE_STORE 7'b0100011

`endif

/* mem_pkg.sv */
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

    // Encoded like funct3 of the load and store instructions
    typedef enum logic [2:0] {
        ACC_BYTE   = 3'b000,
        ACC_HALF   = 3'b001,
        ACC_WORD   = 3'b010,
        ACC_BYTE_U = 3'b100,
        ACC_HALF_U = 3'b101
    } acc_width_e;

    // One instruction word, seen as I-type (loads) or S-type (stores)
    typedef union packed {
        struct packed {
            logic [11:0]                    imm;
            logic [`MEM_REG_ADDR_WIDTH-1:0] rs1;
            logic [2:0]                     funct3;
            logic [`MEM_REG_ADDR_WIDTH-1:0] rd;
            logic [6:0]                     opcode;
        } i;
        struct packed {
            logic [6:0]                     imm_hi;
            logic [`MEM_REG_ADDR_WIDTH-1:0] rs2;
            logic [`MEM_REG_ADDR_WIDTH-1:0] rs1;
            logic [2:0]                     funct3;
            logic [4:0]                     imm_lo;
            logic [6:0]                     opcode;
        } s;
    } inst_view_u;

endpackage

`default_nettype wire

/* lsu_ctrl.sv */
`default_nettype none

`include "mem_defines.svh"

module lsu_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           exu_done_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     pc_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     inst_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     result_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     addr_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     rs2_data_i,
    input  wire logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  wire logic                           rvalid_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     rdata_i,
    input  wire logic                           bvalid_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     load_data_i,
    output logic [`MEM_DATA_WIDTH-1:0]          pc_o,
    output logic [`MEM_DATA_WIDTH-1:0]          inst_o,
    output logic [`MEM_DATA_WIDTH-1:0]          result_o,
    output logic [`MEM_REG_ADDR_WIDTH-1:0]      rd_addr_o,
    output logic [`MEM_DATA_WIDTH-1:0]          addr_o,
    output logic [`MEM_DATA_WIDTH-1:0]          store_data_o,
    output mem_pkg::acc_width_e                 width_o,
    output logic                                awvalid_o,
    output logic                                wvalid_o,
    output logic                                arvalid_o,
    output logic                                rready_o,
    output logic                                bready_o,
    output logic                                mem_done_o,
    output logic                                mem_active_o,
    output logic [`MEM_DATA_WIDTH-1:0]          load_data_o,
    output logic [`MEM_DATA_WIDTH-1:0]          rdata_q_o
);
    import mem_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACCESS = 2'd1;
    localparam logic [1:0] ST_DONE   = 2'd2;

    logic [1:0]                 state_q;
    logic                       aw_req_q;
    logic                       ar_req_q;
    logic [`MEM_DATA_WIDTH-1:0] load_data_q;
    logic [`MEM_DATA_WIDTH-1:0] rdata_q;
    inst_view_u                 inst_in_v;
    inst_view_u                 inst_v;
    logic                       is_load;
    logic                       is_store;
    logic                       resp_fire;

    // Incoming word decides the request kind, latched word drives the rest
    assign inst_in_v = inst_i;
    assign inst_v    = inst_o;
    assign is_load   = (inst_v.i.opcode == `MEM_OPCODE_LOAD);
    assign is_store  = (inst_v.s.opcode == `MEM_OPCODE_STORE);
    assign width_o   = acc_width_e'(inst_v.i.funct3);

    assign awvalid_o    = aw_req_q;
    assign wvalid_o     = aw_req_q;
    assign arvalid_o    = ar_req_q;
    assign rready_o     = (state_q == ST_ACCESS);
    assign bready_o     = (state_q == ST_ACCESS);
    assign mem_active_o = (state_q == ST_ACCESS);
    assign mem_done_o   = (state_q == ST_DONE);
    assign resp_fire    = (rvalid_i && rready_o) || (bvalid_i && bready_o);
    assign rdata_q_o    = rdata_q;

    // Aligned word goes straight out in the done cycle, then is held
    assign load_data_o = (mem_done_o && is_load) ? load_data_i : load_data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            aw_req_q     <= 1'b0;
            ar_req_q     <= 1'b0;
            pc_o         <= '0;
            inst_o       <= '0;
            result_o     <= '0;
            rd_addr_o    <= '0;
            addr_o       <= '0;
            store_data_o <= '0;
        end else begin
            // Requests last a single cycle
            aw_req_q <= 1'b0;
            ar_req_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (exu_done_i) begin
                        pc_o         <= pc_i;
                        inst_o       <= inst_i;
                        result_o     <= result_i;
                        rd_addr_o    <= rd_addr_i;
                        addr_o       <= addr_i;
                        store_data_o <= rs2_data_i;
                        aw_req_q     <= (inst_in_v.s.opcode == `MEM_OPCODE_STORE);
                        ar_req_q     <= (inst_in_v.i.opcode == `MEM_OPCODE_LOAD);
                        state_q      <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (resp_fire) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Read word on the R handshake, aligned data when the load retires
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata_q     <= '0;
            load_data_q <= '0;
        end else begin
            if (rvalid_i && rready_o) begin
                rdata_q <= rdata_i;
            end
            if (mem_done_o && is_load) begin
                load_data_q <= load_data_i;
            end
        end
    end

    // Execute must not start a new access while this one is in flight
    a_no_exu_done_busy: assert property (
        @(posedge clk) disable iff (rst) exu_done_i |-> state_q == ST_IDLE);

    a_access_is_mem_op: assert property (
        @(posedge clk) disable iff (rst) state_q == ST_ACCESS |-> is_load || is_store);

    // Misaligned accesses are outside this stage
    a_half_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == ST_ACCESS && (width_o == ACC_HALF || width_o == ACC_HALF_U))
        |-> addr_o[0] == 1'b0);

    a_word_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == ST_ACCESS && width_o == ACC_WORD) |-> addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* load_align.sv */
`default_nettype none

`include "mem_defines.svh"

module load_align (
    input  wire logic [`MEM_DATA_WIDTH-1:0] rdata_i,
    input  wire logic [1:0]                 addr_lo_i,
    input  mem_pkg::acc_width_e             width_i,
    output logic [`MEM_DATA_WIDTH-1:0]      load_data_o
);
    import mem_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Lane picked by the low address bits
    always_comb begin
        case (addr_lo_i)
            2'd0:    byte_lane = rdata_i[7:0];
            2'd1:    byte_lane = rdata_i[15:8];
            2'd2:    byte_lane = rdata_i[23:16];
            default: byte_lane = rdata_i[31:24];
        endcase
        half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    always_comb begin
        case (width_i)
            ACC_BYTE: begin
                load_data_o = {{(`MEM_DATA_WIDTH - 8){byte_lane[7]}}, byte_lane};
            end
            ACC_BYTE_U: begin
                load_data_o = {{(`MEM_DATA_WIDTH - 8){1'b0}}, byte_lane};
            end
            ACC_HALF: begin
                load_data_o = {{(`MEM_DATA_WIDTH - 16){half_lane[15]}}, half_lane};
            end
            ACC_HALF_U: begin
                load_data_o = {{(`MEM_DATA_WIDTH - 16){1'b0}}, half_lane};
            end
            // Word loads pass through
            default: begin
                load_data_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

/* store_mask_gen.sv */
`default_nettype none

`include "mem_defines.svh"

module store_mask_gen (
    input  wire logic [`MEM_DATA_WIDTH-1:0] store_data_i,
    input  wire logic [1:0]                 addr_lo_i,
    input  mem_pkg::acc_width_e             width_i,
    output logic [`MEM_DATA_WIDTH-1:0]      wdata_o,
    output logic [`MEM_DATA_WIDTH/8-1:0]    wstrb_o
);
    import mem_pkg::*;

    always_comb begin
        case (width_i)
            // Byte copied into every lane, one strobe bit
            ACC_BYTE, ACC_BYTE_U: begin
                wdata_o = {4{store_data_i[7:0]}};
                wstrb_o = 4'b0001 << addr_lo_i;
            end
            // Halfword in both halves, strobe on the addressed pair
            ACC_HALF, ACC_HALF_U: begin
                wdata_o = {2{store_data_i[15:0]}};
                wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

/* axi_lite_sram.sv */
`default_nettype none

`include "mem_defines.svh"

module axi_lite_sram (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         awvalid_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]   awaddr_i,
    input  wire logic                         wvalid_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]   wdata_i,
    input  wire logic [`MEM_DATA_WIDTH/8-1:0] wstrb_i,
    input  wire logic                         bready_i,
    input  wire logic                         arvalid_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]   araddr_i,
    input  wire logic                         rready_i,
    output logic                              bvalid_o,
    output logic                              rvalid_o,
    output logic [`MEM_DATA_WIDTH-1:0]        rdata_o
);
    localparam int IDX_W = $clog2(`MEM_SRAM_WORDS);
    localparam int LANES = `MEM_DATA_WIDTH / 8;

    logic [`MEM_DATA_WIDTH-1:0] mem_q [0:`MEM_SRAM_WORDS-1];
    logic [IDX_W-1:0]           widx;
    logic [IDX_W-1:0]           ridx;
    logic                       awready;
    logic                       arready;
    logic                       wr_fire;
    logic                       rd_fire;

    // Always ready for a new address
    assign awready = 1'b1;
    assign arready = 1'b1;

    assign wr_fire = awvalid_i && awready && wvalid_i;
    assign rd_fire = arvalid_i && arready;

    // Word index from the byte address
    assign widx = awaddr_i[IDX_W+1:2];
    assign ridx = araddr_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < LANES; b++) begin
                if (wstrb_i[b]) begin
                    mem_q[widx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
        if (rd_fire) begin
            rdata_o <= mem_q[ridx];
        end
    end

    // Response pending flags, held until the master takes them
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // Master sends write address and data in the same cycle
    a_aw_w_together: assert property (
        @(posedge clk) disable iff (rst) awvalid_i == wvalid_i);

endmodule

`default_nettype wire

/* mem_stage_top.sv */
`default_nettype none

`include "mem_defines.svh"

module mem_stage_top (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           exu_done_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     pc_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     inst_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     result_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     addr_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     rs2_data_i,
    input  wire logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr_i,
    output logic [`MEM_DATA_WIDTH-1:0]          pc_o,
    output logic [`MEM_DATA_WIDTH-1:0]          inst_o,
    output logic [`MEM_DATA_WIDTH-1:0]          result_o,
    output logic [`MEM_REG_ADDR_WIDTH-1:0]      rd_addr_o,
    output logic [`MEM_DATA_WIDTH-1:0]          load_data_o,
    output logic                                mem_done_o,
    output logic                                mem_active_o
);
    import mem_pkg::*;

    logic [`MEM_DATA_WIDTH-1:0]   addr;
    logic [`MEM_DATA_WIDTH-1:0]   store_data;
    acc_width_e                   width;
    logic                         awvalid;
    logic                         wvalid;
    logic                         arvalid;
    logic                         rready;
    logic                         bready;
    logic                         bvalid;
    logic                         rvalid;
    logic [`MEM_DATA_WIDTH-1:0]   rdata;
    logic [`MEM_DATA_WIDTH-1:0]   rdata_q;
    logic [`MEM_DATA_WIDTH-1:0]   aligned_data;
    logic [`MEM_DATA_WIDTH-1:0]   wdata;
    logic [`MEM_DATA_WIDTH/8-1:0] wstrb;

    lsu_ctrl u_lsu_ctrl (
        .clk          (clk),
        .rst          (rst),
        .exu_done_i   (exu_done_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .result_i     (result_i),
        .addr_i       (addr_i),
        .rs2_data_i   (rs2_data_i),
        .rd_addr_i    (rd_addr_i),
        .rvalid_i     (rvalid),
        .rdata_i      (rdata),
        .bvalid_i     (bvalid),
        .load_data_i  (aligned_data),
        .pc_o         (pc_o),
        .inst_o       (inst_o),
        .result_o     (result_o),
        .rd_addr_o    (rd_addr_o),
        .addr_o       (addr),
        .store_data_o (store_data),
        .width_o      (width),
        .awvalid_o    (awvalid),
        .wvalid_o     (wvalid),
        .arvalid_o    (arvalid),
        .rready_o     (rready),
        .bready_o     (bready),
        .mem_done_o   (mem_done_o),
        .mem_active_o (mem_active_o),
        .load_data_o  (load_data_o),
        .rdata_q_o    (rdata_q)
    );

    load_align u_load_align (
        .rdata_i     (rdata_q),
        .addr_lo_i   (addr[1:0]),
        .width_i     (width),
        .load_data_o (aligned_data)
    );

    store_mask_gen u_store_mask_gen (
        .store_data_i (store_data),
        .addr_lo_i    (addr[1:0]),
        .width_i      (width),
        .wdata_o      (wdata),
        .wstrb_o      (wstrb)
    );

    axi_lite_sram u_sram (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid),
        .awaddr_i  (addr),
        .wvalid_i  (wvalid),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .bready_i  (bready),
        .arvalid_i (arvalid),
        .araddr_i  (addr),
        .rready_i  (rready),
        .bvalid_o  (bvalid),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    // Starts low, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

`include "mem_defines.svh"

module tb_checker (
    input  wire logic                           clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           exu_done_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     drv_pc_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     drv_inst_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     drv_result_i,
    input  wire logic [`MEM_REG_ADDR_WIDTH-1:0] drv_rd_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     exp_load_i,
    input  wire logic                           exp_is_load_i,
    input  wire logic [31:0]                    row_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     pc_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     inst_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     result_i,
    input  wire logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr_i,
    input  wire logic [`MEM_DATA_WIDTH-1:0]     load_data_i,
    input  wire logic                           mem_done_i,
    input  wire logic                           mem_active_i,
    output int                                  rows_done_o,
    output int                                  pass_cnt_o,
    output int                                  fail_cnt_o
);

    // Cycles after the exu_done_i sample before a row counts as lost
    localparam int DONE_LIMIT = 6;

    logic                           tracking;
    logic                           drop_pending;
    logic                           reset_checked;
    int                             since;
    int                             row_errs;
    logic [`MEM_DATA_WIDTH-1:0]     exp_pc;
    logic [`MEM_DATA_WIDTH-1:0]     exp_inst;
    logic [`MEM_DATA_WIDTH-1:0]     exp_result;
    logic [`MEM_REG_ADDR_WIDTH-1:0] exp_rd;
    logic [`MEM_DATA_WIDTH-1:0]     last_load;

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            row_errs = row_errs + 1;
        end
    endtask

    task automatic finish_test(input string what);
        if (row_errs == 0) begin
            $display("%s: ok", what);
            pass_cnt_o = pass_cnt_o + 1;
        end else begin
            $display("%s: %0d error(s)", what, row_errs);
            fail_cnt_o = fail_cnt_o + 1;
        end
    endtask

    // Everything is sampled mid-cycle, away from the driving edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            tracking      = 1'b0;
            drop_pending  = 1'b0;
            reset_checked = 1'b0;
            since         = 0;
            row_errs      = 0;
            last_load     = '0;
            rows_done_o   = 0;
            pass_cnt_o    = 0;
            fail_cnt_o    = 0;
        end else if (!reset_checked) begin
            reset_checked = 1'b1;
            row_errs      = 0;
            check_word("mem_done_o", 32'(mem_done_i), 32'h0);
            check_word("mem_active_o", 32'(mem_active_i), 32'h0);
            check_word("pc_o", pc_i, 32'h0);
            check_word("inst_o", inst_i, 32'h0);
            check_word("result_o", result_i, 32'h0);
            check_word("rd_addr_o", 32'(rd_addr_i), 32'h0);
            finish_test("reset values");
        end else if (drop_pending) begin
            // Done must be a single-cycle pulse
            drop_pending = 1'b0;
            check_word("mem_done_o", 32'(mem_done_i), 32'h0);
            finish_test($sformatf("row %0d", row_i));
            rows_done_o = rows_done_o + 1;
        end else if (tracking) begin
            since = since + 1;
            if (since <= 2) begin
                check_word("mem_active_o", 32'(mem_active_i), 32'h1);
                check_word("mem_done_o", 32'(mem_done_i), 32'h0);
            end else if (mem_done_i) begin
                if (since != 3) begin
                    $display("row %0d: mem_done_o came %0d cycles after exu_done_i, not 3",
                             row_i, since);
                    row_errs = row_errs + 1;
                end
                check_word("mem_active_o", 32'(mem_active_i), 32'h0);
                check_word("pc_o", pc_i, exp_pc);
                check_word("inst_o", inst_i, exp_inst);
                check_word("result_o", result_i, exp_result);
                check_word("rd_addr_o", 32'(rd_addr_i), 32'(exp_rd));
                if (exp_is_load_i) begin
                    check_word("load_data_o", load_data_i, exp_load_i);
                    last_load = exp_load_i;
                end else begin
                    // A store leaves the last load result in place
                    check_word("load_data_o", load_data_i, last_load);
                end
                tracking     = 1'b0;
                drop_pending = 1'b1;
            end else if (since > DONE_LIMIT) begin
                $display("row %0d: mem_done_o never came within %0d cycles", row_i, DONE_LIMIT);
                row_errs = row_errs + 1;
                tracking = 1'b0;
                finish_test($sformatf("row %0d", row_i));
                rows_done_o = rows_done_o + 1;
            end
        end else if (exu_done_i) begin
            // Start of a row, remember what the execute side drove
            tracking   = 1'b1;
            since      = 0;
            row_errs   = 0;
            exp_pc     = drv_pc_i;
            exp_inst   = drv_inst_i;
            exp_result = drv_result_i;
            exp_rd     = drv_rd_i;
            check_word("mem_active_o", 32'(mem_active_i), 32'h0);
            check_word("mem_done_o", 32'(mem_done_i), 32'h0);
        end
    end

endmodule

`default_nettype wire

/* tb_mem_stage.sv */
`default_nettype none

`include "mem_defines.svh"

module tb_mem_stage;
    import mem_pkg::*;

    localparam int N_ROWS       = 13;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 16;

    logic                           clk;
    logic                           rst;
    logic                           exu_done;
    logic [`MEM_DATA_WIDTH-1:0]     pc;
    logic [`MEM_DATA_WIDTH-1:0]     inst;
    logic [`MEM_DATA_WIDTH-1:0]     result;
    logic [`MEM_DATA_WIDTH-1:0]     addr;
    logic [`MEM_DATA_WIDTH-1:0]     rs2_data;
    logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr;
    logic [`MEM_DATA_WIDTH-1:0]     pc_out;
    logic [`MEM_DATA_WIDTH-1:0]     inst_out;
    logic [`MEM_DATA_WIDTH-1:0]     result_out;
    logic [`MEM_REG_ADDR_WIDTH-1:0] rd_addr_out;
    logic [`MEM_DATA_WIDTH-1:0]     load_data;
    logic                           mem_done;
    logic                           mem_active;
    logic [`MEM_DATA_WIDTH-1:0]     exp_load;
    logic                           exp_is_load;
    logic [31:0]                    row_idx;
    int                             rows_done;
    int                             pass_cnt;
    int                             fail_cnt;

    // Stimulus table, one entry per access
    logic [31:0]                    tab_inst [0:N_ROWS-1];
    logic [31:0]                    tab_addr [0:N_ROWS-1];
    logic [31:0]                    tab_wdata [0:N_ROWS-1];
    logic [31:0]                    tab_pc [0:N_ROWS-1];
    logic [31:0]                    tab_result [0:N_ROWS-1];
    logic [31:0]                    tab_exp [0:N_ROWS-1];
    logic [`MEM_REG_ADDR_WIDTH-1:0] tab_rd [0:N_ROWS-1];
    logic                           tab_is_load [0:N_ROWS-1];
    logic [31:0]                    shadow [0:`MEM_SRAM_WORDS-1];
    int                             row_cnt;

    tb_clk_gen #(.PERIOD(PERIOD)) u_clk_gen (.clk_o(clk));

    mem_stage_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .exu_done_i   (exu_done),
        .pc_i         (pc),
        .inst_i       (inst),
        .result_i     (result),
        .addr_i       (addr),
        .rs2_data_i   (rs2_data),
        .rd_addr_i    (rd_addr),
        .pc_o         (pc_out),
        .inst_o       (inst_out),
        .result_o     (result_out),
        .rd_addr_o    (rd_addr_out),
        .load_data_o  (load_data),
        .mem_done_o   (mem_done),
        .mem_active_o (mem_active)
    );

    tb_checker u_chk (
        .clk_i         (clk),
        .rst_i         (rst),
        .exu_done_i    (exu_done),
        .drv_pc_i      (pc),
        .drv_inst_i    (inst),
        .drv_result_i  (result),
        .drv_rd_i      (rd_addr),
        .exp_load_i    (exp_load),
        .exp_is_load_i (exp_is_load),
        .row_i         (row_idx),
        .pc_i          (pc_out),
        .inst_i        (inst_out),
        .result_i      (result_out),
        .rd_addr_i     (rd_addr_out),
        .load_data_i   (load_data),
        .mem_done_i    (mem_done),
        .mem_active_i  (mem_active),
        .rows_done_o   (rows_done),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt)
    );

    // Memory word after a store writes its bytes into the addressed lanes
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] lo,
                                                input acc_width_e width, input logic [31:0] data);
        logic [31:0] word;
        word = old;
        case (width)
            ACC_BYTE, ACC_BYTE_U: word[8*lo +: 8] = data[7:0];
            ACC_HALF, ACC_HALF_U: word[8*lo +: 16] = data[15:0];
            default: word = data;
        endcase
        return word;
    endfunction

    // Register value a load of this width gives from a memory word
    function automatic logic [31:0] load_expect(input logic [31:0] word, input logic [1:0] lo,
                                                input acc_width_e width);
        logic [31:0] shifted;
        shifted = word >> (8 * lo);
        case (width)
            ACC_BYTE:   return 32'(signed'(shifted[7:0]));
            ACC_HALF:   return 32'(signed'(shifted[15:0]));
            ACC_BYTE_U: return 32'(shifted[7:0]);
            ACC_HALF_U: return 32'(shifted[15:0]);
            default:    return word;
        endcase
    endfunction

    task automatic add_access(input logic is_load, input acc_width_e width,
                              input logic [31:0] a, input logic [31:0] data);
        inst_view_u v;
        logic [7:0] idx;
        v   = '0;
        idx = a[9:2];
        if (is_load) begin
            v.i.opcode = `MEM_OPCODE_LOAD;
            v.i.funct3 = width;
            v.i.rs1    = 5'd2;
            v.i.rd     = 5'(row_cnt + 1);
            tab_exp[row_cnt] = load_expect(shadow[idx], a[1:0], width);
        end else begin
            v.s.opcode = `MEM_OPCODE_STORE;
            v.s.funct3 = width;
            v.s.rs1    = 5'd2;
            v.s.rs2    = 5'd3;
            shadow[idx] = merge_store(shadow[idx], a[1:0], width, data);
            tab_exp[row_cnt] = '0;
        end
        tab_is_load[row_cnt] = is_load;
        tab_inst[row_cnt]    = v;
        tab_addr[row_cnt]    = a;
        tab_wdata[row_cnt]   = data;
        tab_rd[row_cnt]      = 5'(row_cnt + 1);
        // Only the tags are random
        tab_pc[row_cnt]      = 32'h0000_1000 | ($urandom & 32'h0000_0FFC);
        tab_result[row_cnt]  = $urandom;
        row_cnt = row_cnt + 1;
    endtask

    initial begin
        rst         = 1'b1;
        exu_done    = 1'b0;
        pc          = '0;
        inst        = '0;
        result      = '0;
        addr        = '0;
        rs2_data    = '0;
        rd_addr     = '0;
        exp_load    = '0;
        exp_is_load = 1'b0;
        row_idx     = '0;
        row_cnt     = 0;
        void'($urandom(25));

        add_access(1'b0, ACC_WORD, 32'h40, 32'h1234_5678);
        add_access(1'b1, ACC_WORD, 32'h40, 32'h0);
        // Known word, then one byte and one halfword into it
        add_access(1'b0, ACC_WORD, 32'h44, 32'hA1B2_C3D4);
        add_access(1'b0, ACC_BYTE, 32'h45, 32'h1234_56E7);
        add_access(1'b0, ACC_HALF, 32'h46, 32'hDEAD_5F6A);
        add_access(1'b1, ACC_WORD, 32'h44, 32'h0);
        // Negative byte 0, byte 3 and upper half
        add_access(1'b0, ACC_WORD, 32'h48, 32'h80F2_7F91);
        add_access(1'b1, ACC_BYTE, 32'h48, 32'h0);
        add_access(1'b1, ACC_BYTE_U, 32'h48, 32'h0);
        add_access(1'b1, ACC_HALF, 32'h4A, 32'h0);
        add_access(1'b1, ACC_HALF_U, 32'h4A, 32'h0);
        add_access(1'b1, ACC_BYTE, 32'h49, 32'h0);
        add_access(1'b1, ACC_BYTE, 32'h4B, 32'h0);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < N_ROWS; r++) begin
            @(posedge clk);
            row_idx     <= 32'(r);
            pc          <= tab_pc[r];
            inst        <= tab_inst[r];
            result      <= tab_result[r];
            addr        <= tab_addr[r];
            rs2_data    <= tab_wdata[r];
            rd_addr     <= tab_rd[r];
            exp_load    <= tab_exp[r];
            exp_is_load <= tab_is_load[r];
            exu_done    <= 1'b1;
            @(posedge clk);
            exu_done <= 1'b0;
            while (rows_done < r + 1) @(posedge clk);
        end

        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == N_ROWS + 1) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Eight cycles per row on top of reset
    initial begin
        #((RESET_CYCLES + N_ROWS * 8) * PERIOD);
        $display("Watchdog expired after %0d of %0d rows", rows_done, N_ROWS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_stage_top.f */
+incdir+.
mem_pkg.sv
lsu_ctrl.sv
load_align.sv
store_mask_gen.sv
axi_lite_sram.sv
mem_stage_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_mem_stage.sv

/* run.sh */
#!/bin/sh
# Build the memory-stage testbench with Verilator, run it, then look for the pass line
rm -f build.log sim.log &&
verilator --binary --timing --assert -f mem_stage_top.f --top-module tb_mem_stage \
    -o sim_mem_stage > build.log 2>&1 &&
./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log || { echo "run.sh: simulation failed, see build.log and sim.log"; exit 1; }
